/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_dispatcher
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/cpu_msg_pkg.sv */
package cpu_msg_pkg;

  // messages a cpu may send at the end of its slot
  typedef enum logic [7:0] {
    CPU_R_NONE  = 8'h00,
    CPU_R_START = 8'h01,
    CPU_R_END   = 8'h02
  } cpu_msg_e;

  // which pool the granted slot belongs to
  typedef enum logic {
    SLOT_ACTIVE    = 1'b0,
    SLOT_NONACTIVE = 1'b1
  } slot_kind_e;

  // slot grant, q is a one-cycle strobe
  typedef struct packed {
    logic                   q;
    slot_kind_e             kind;
    disp_cfg_pkg::cpu_idx_t index;
  } cpu_sel_t;

  // cpu side request, held until done
  typedef struct packed {
    logic                read_q;
    logic                write_q;
    disp_cfg_pkg::addr_t addr;
    disp_cfg_pkg::data_t data;
  } cpu_req_t;

  // result back to the cpu
  typedef struct packed {
    logic                read_dn;
    logic                write_dn;
    disp_cfg_pkg::addr_t addr;
    disp_cfg_pkg::data_t data;
  } cpu_resp_t;

  // external memory request
  typedef struct packed {
    logic                read_q;
    logic                write_q;
    disp_cfg_pkg::addr_t addr;
    disp_cfg_pkg::data_t data;
  } mem_req_t;

  // external memory reply
  typedef struct packed {
    logic                read_dn;
    logic                write_dn;
    disp_cfg_pkg::addr_t addr;
    disp_cfg_pkg::data_t data;
  } mem_resp_t;

  // access accepted by the command stage, one-cycle pulse
  typedef struct packed {
    logic                read;
    logic                write;
    disp_cfg_pkg::addr_t addr;
    disp_cfg_pkg::data_t data;
  } mem_cmd_t;

  // slot outcome for the scheduler
  typedef struct packed {
    logic ack;
    logic start;
    logic stop;
  } cpu_event_t;

endpackage

/* common/disp_cfg_pkg.sv */
package disp_cfg_pkg;

  // bus widths
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;

  // cpu number width, also bounds the cpu count
  parameter int CPU_IDX_W = 8;

  // cpu count used when the top level is not overridden
  parameter int CPU_QUANTITY_DEF = 4;

  // one bus address
  typedef logic [ADDR_W-1:0] addr_t;

  // one bus data word
  typedef logic [DATA_W-1:0] data_t;

  // cpu number as carried in a slot grant
  typedef logic [CPU_IDX_W-1:0] cpu_idx_t;

endpackage

/* mem_port/mem_access_stage.sv */
`timescale 1ns/10ps

module mem_access_stage (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_msg_pkg::mem_cmd_t  mem_cmd,
  output cpu_msg_pkg::mem_req_t  mem_req,
  input  cpu_msg_pkg::mem_resp_t mem_resp,
  output cpu_msg_pkg::cpu_resp_t cpu_resp,
  output logic                   bus_busy
);

  // kind of the outstanding access
  logic rd_pend;
  logic wr_pend;

  // done from memory that matches what is pending
  logic rd_done;
  logic wr_done;

  assign rd_done = rd_pend && mem_resp.read_dn;
  assign wr_done = wr_pend && mem_resp.write_dn;

  // busy from strobe until the result pulse
  assign bus_busy = rd_pend | wr_pend;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend  <= 1'b0;
      wr_pend  <= 1'b0;
      mem_req  <= '0;
      cpu_resp <= '0;
    end else begin
      // strobes and result are single cycle
      mem_req.read_q  <= 1'b0;
      mem_req.write_q <= 1'b0;
      cpu_resp        <= '0;
      if (mem_cmd.read || mem_cmd.write) begin
        rd_pend         <= mem_cmd.read;
        wr_pend         <= mem_cmd.write;
        mem_req.read_q  <= mem_cmd.read;
        mem_req.write_q <= mem_cmd.write;
        // addr and data stay on the port while memory works
        mem_req.addr    <= mem_cmd.addr;
        mem_req.data    <= mem_cmd.data;
      end else if (rd_done || wr_done) begin
        rd_pend           <= 1'b0;
        wr_pend           <= 1'b0;
        mem_req.addr      <= '0;
        mem_req.data      <= '0;
        // reply goes to the cpu as memory gave it
        cpu_resp.read_dn  <= rd_done;
        cpu_resp.write_dn <= wr_done;
        cpu_resp.addr     <= mem_resp.addr;
        cpu_resp.data     <= mem_resp.data;
      end
    end
  end

endmodule

/* scheduler/cpu_scheduler.sv */
`timescale 1ns/10ps

module cpu_scheduler #(
  parameter int CPU_QUANTITY = disp_cfg_pkg::CPU_QUANTITY_DEF
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cpu_rst_done,
  output logic                    cpu_rst,
  input  cpu_msg_pkg::cpu_event_t cpu_event,
  input  cpu_msg_pkg::cpu_resp_t  cpu_resp,
  output cpu_msg_pkg::cpu_sel_t   cpu_sel
);

  // one spare bit so a full count of 2**CPU_IDX_W fits
  localparam int CNT_W = disp_cfg_pkg::CPU_IDX_W + 1;

  typedef enum logic {
    ST_RST_WAIT,
    ST_SLOT
  } sched_state_e;

  sched_state_e     state;
  logic [CNT_W-1:0] num_a;
  logic [CNT_W-1:0] num_na;
  logic [CNT_W-1:0] cursor;
  logic             na_offered;

  // counters after this cycle's event
  logic [CNT_W-1:0] a_upd;
  logic [CNT_W-1:0] na_upd;
  logic [CNT_W-1:0] cur_upd;
  logic             flag_upd;

  // grant choice
  logic [CNT_W-1:0] cur_next;
  logic             grant_na;
  logic             slot_end;
  logic             issue;

  // slot is over on a message or on a returned access
  assign slot_end = cpu_event.ack | cpu_resp.read_dn | cpu_resp.write_dn;

  assign issue = ((state == ST_RST_WAIT) && cpu_rst_done) ||
                 ((state == ST_SLOT) && slot_end);

  always_comb begin
    a_upd    = num_a;
    na_upd   = num_na;
    cur_upd  = cursor;
    flag_upd = na_offered;
    // start moves one cpu into the active pool
    if (cpu_event.start && (num_na != '0)) begin
      na_upd   = num_na - 1'b1;
      a_upd    = num_a + 1'b1;
      cur_upd  = cursor + 1'b1;
      flag_upd = 1'b0;
    end else if (cpu_event.stop && (num_a != '0)) begin
      a_upd  = num_a - 1'b1;
      na_upd = num_na + 1'b1;
    end
    // every other grant to a non-active slot while any are left
    grant_na = (na_upd != '0) && !flag_upd;
    // round robin over active cpus, 0 when the pool is empty
    cur_next = cur_upd + 1'b1;
    if (cur_next >= a_upd) begin
      cur_next = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_RST_WAIT;
      cpu_rst    <= 1'b1;
      num_a      <= '0;
      num_na     <= CNT_W'(CPU_QUANTITY);
      cursor     <= '0;
      na_offered <= 1'b0;
      cpu_sel    <= '0;
    end else begin
      cpu_rst   <= 1'b0;
      cpu_sel.q <= 1'b0;
      num_a     <= a_upd;
      num_na    <= na_upd;
      cursor    <= cur_upd;
      na_offered <= flag_upd;
      if (issue) begin
        state     <= ST_SLOT;
        cpu_sel.q <= 1'b1;
        if (grant_na) begin
          // new cpus always come in through slot 0
          cpu_sel.kind  <= cpu_msg_pkg::SLOT_NONACTIVE;
          cpu_sel.index <= '0;
          na_offered    <= 1'b1;
        end else begin
          cpu_sel.kind  <= cpu_msg_pkg::SLOT_ACTIVE;
          cpu_sel.index <= disp_cfg_pkg::cpu_idx_t'(cur_next);
          cursor        <= cur_next;
          na_offered    <= 1'b0;
        end
      end
    end
  end

endmodule

/* sim.f */
common/disp_cfg_pkg.sv
common/cpu_msg_pkg.sv
scheduler/cpu_scheduler.sv
verilog/cpu_cmd_stage.sv
mem_port/mem_access_stage.sv
verilog/dispatcher_top.sv
tests/tb_clock_gen.sv
tests/tb_dispatcher.sv

/* tests/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

/* tests/tb_dispatcher.sv */
`timescale 1ns/10ps

module tb_dispatcher;

  localparam int NUM_SLOTS  = 200;
  localparam int WAIT_LIMIT = 20;

  logic                   clk;
  logic                   rst;
  logic                   cpu_rst;
  logic                   cpu_rst_done;
  cpu_msg_pkg::cpu_sel_t  cpu_sel;
  cpu_msg_pkg::cpu_req_t  cpu_req;
  cpu_msg_pkg::cpu_msg_e  cpu_msg_in;
  logic                   cpu_ack;
  cpu_msg_pkg::cpu_resp_t cpu_resp;
  cpu_msg_pkg::mem_req_t  mem_req;
  cpu_msg_pkg::mem_resp_t mem_resp;
  logic                   bus_busy;

  // lcg state, error counts
  logic [31:0] rng_state    = 32'd25180;
  int          value_errors = 0;
  int          other_errors = 0;

  // scheduler reference model
  int m_active    = 0;
  int m_nonactive = 4;
  int m_cursor    = 0;
  bit m_na_flag   = 1'b0;
  int n_start     = 0;
  int n_end       = 0;

  // memory model contents, delay picked per access
  disp_cfg_pkg::data_t mem_array [16];
  int                  mem_delay = 0;

  tb_clock_gen #(.PERIOD_NS(40)) i_tb_clock_gen (.clk(clk));

  dispatcher_top #(
    .CPU_QUANTITY(4)
  ) i_dispatcher_top (
    .clk         (clk),
    .rst         (rst),
    .cpu_rst     (cpu_rst),
    .cpu_rst_done(cpu_rst_done),
    .cpu_sel     (cpu_sel),
    .cpu_req     (cpu_req),
    .cpu_msg_in  (cpu_msg_in),
    .cpu_ack     (cpu_ack),
    .cpu_resp    (cpu_resp),
    .mem_req     (mem_req),
    .mem_resp    (mem_resp),
    .bus_busy    (bus_busy)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // upper bits only, low lcg bits repeat quickly
  function automatic int rand_below(input int n);
    return int'(next_rand() >> 8) % n;
  endfunction

  // sample point and drive point, 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_sel(input string name, input cpu_msg_pkg::cpu_sel_t got,
                           input cpu_msg_pkg::cpu_sel_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_resp(input string name, input cpu_msg_pkg::cpu_resp_t got,
                            input cpu_msg_pkg::cpu_resp_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_mem_req(input string name, input cpu_msg_pkg::mem_req_t got,
                               input cpu_msg_pkg::mem_req_t exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // nothing moves on the bus outside an access
  task automatic check_quiet();
    check_bit("mem_req.read_q", mem_req.read_q, 1'b0);
    check_bit("mem_req.write_q", mem_req.write_q, 1'b0);
    check_resp("cpu_resp", cpu_resp, '0);
    check_bit("bus_busy", bus_busy, 1'b0);
  endtask

  // every other grant to a non-active slot while any are left
  task automatic model_grant(output cpu_msg_pkg::cpu_sel_t exp);
    exp   = '0;
    exp.q = 1'b1;
    if (m_nonactive > 0 && !m_na_flag) begin
      exp.kind  = cpu_msg_pkg::SLOT_NONACTIVE;
      m_na_flag = 1'b1;
    end else begin
      // round robin, wraps at the active count
      m_cursor  = (m_cursor + 1 >= m_active) ? 0 : m_cursor + 1;
      exp.kind  = cpu_msg_pkg::SLOT_ACTIVE;
      exp.index = disp_cfg_pkg::cpu_idx_t'(m_cursor);
      m_na_flag = 1'b0;
    end
  endtask

  task automatic wait_grant(output bit ok);
    int n;
    ok = 1'b0;
    n  = 0;
    while (!ok && n < WAIT_LIMIT) begin
      tick();
      check_quiet();
      ok = cpu_sel.q;
      n++;
    end
    if (!ok) begin
      $display("Timeout at %0t: no slot grant within %0d cycles", $time, WAIT_LIMIT);
      other_errors++;
    end
  endtask

  task automatic run_access(input bit is_write, output bit ok);
    cpu_msg_pkg::mem_req_t  exp_req;
    cpu_msg_pkg::mem_req_t  exp_hold;
    cpu_msg_pkg::mem_req_t  zero_req;
    cpu_msg_pkg::cpu_resp_t exp_resp;
    int                     n;
    int                     strobes;
    bit                     strobe_now;
    zero_req        = '0;
    cpu_req.read_q  = !is_write;
    cpu_req.write_q = is_write;
    cpu_req.addr    = next_rand() & 32'hffff_fffc;
    cpu_req.data    = next_rand();
    mem_delay       = rand_below(6);
    // reads go out with no data
    exp_req.read_q   = !is_write;
    exp_req.write_q  = is_write;
    exp_req.addr     = cpu_req.addr;
    exp_req.data     = is_write ? cpu_req.data : '0;
    exp_hold         = exp_req;
    exp_hold.read_q  = 1'b0;
    exp_hold.write_q = 1'b0;
    exp_resp.read_dn  = !is_write;
    exp_resp.write_dn = is_write;
    exp_resp.addr     = cpu_req.addr;
    exp_resp.data     = is_write ? cpu_req.data : mem_array[cpu_req.addr[5:2]];
    ok      = 1'b0;
    n       = 0;
    strobes = 0;
    while (!ok && n < WAIT_LIMIT) begin
      tick();
      n++;
      // token is held, no grant while busy
      check_bit("cpu_sel.q", cpu_sel.q, 1'b0);
      ok = cpu_resp.read_dn | cpu_resp.write_dn;
      if (!ok) begin
        check_resp("cpu_resp", cpu_resp, '0);
        strobe_now = mem_req.read_q | mem_req.write_q;
        if (strobe_now && strobes == 0) begin
          check_mem_req("mem_req", mem_req, exp_req);
        end else if (strobes > 0) begin
          check_mem_req("mem_req", mem_req, exp_hold);
        end else begin
          check_mem_req("mem_req", mem_req, zero_req);
        end
        if (strobe_now) begin
          strobes++;
        end
        check_bit("bus_busy", bus_busy, strobes > 0);
      end
    end
    cpu_req = '0;
    if (!ok) begin
      $display("Timeout at %0t: access got no done within %0d cycles", $time, WAIT_LIMIT);
      other_errors++;
    end else begin
      check_resp("cpu_resp", cpu_resp, exp_resp);
      // port clears and busy drops with the done pulse
      check_mem_req("mem_req", mem_req, zero_req);
      check_bit("bus_busy", bus_busy, 1'b0);
      if (strobes != 1) begin
        $display("Memory saw %0d strobes for one access at %0t", strobes, $time);
        other_errors++;
      end
    end
  endtask

  task automatic send_msg();
    cpu_msg_pkg::cpu_msg_e msg;
    int                    pick;
    msg  = cpu_msg_pkg::CPU_R_NONE;
    pick = rand_below(3);
    // start needs a non-active cpu, end an active one
    if (pick == 1 && m_nonactive > 0) begin
      msg = cpu_msg_pkg::CPU_R_START;
    end else if (pick == 2 && m_active > 0) begin
      msg = cpu_msg_pkg::CPU_R_END;
    end
    cpu_ack    = 1'b1;
    cpu_msg_in = msg;
    tick();
    check_bit("cpu_sel.q", cpu_sel.q, 1'b0);
    check_quiet();
    cpu_ack    = 1'b0;
    cpu_msg_in = cpu_msg_pkg::CPU_R_NONE;
    if (msg == cpu_msg_pkg::CPU_R_START) begin
      m_nonactive--;
      m_active++;
      m_cursor++;
      m_na_flag = 1'b0;
      n_start++;
    end else if (msg == cpu_msg_pkg::CPU_R_END) begin
      m_active--;
      m_nonactive++;
      n_end++;
    end
  endtask

  task automatic run_slot(output bit ok);
    cpu_msg_pkg::cpu_sel_t exp_sel;
    int                    idle;
    int                    act;
    int                    i;
    model_grant(exp_sel);
    check_sel("cpu_sel", cpu_sel, exp_sel);
    // armed from the cycle after the grant, cpu may stay silent a bit
    idle = 1 + rand_below(3);
    for (i = 0; i < idle; i++) begin
      tick();
      check_bit("cpu_sel.q", cpu_sel.q, 1'b0);
      check_quiet();
    end
    act = rand_below(3);
    ok  = 1'b1;
    if (act == 2) begin
      send_msg();
    end else begin
      run_access(act == 1, ok);
    end
  endtask

  // memory model, answers each strobe after mem_delay cycles
  initial begin
    cpu_msg_pkg::mem_req_t held;
    bit                    busy;
    int                    wait_left;
    int                    i;
    held      = '0;
    busy      = 1'b0;
    wait_left = 0;
    mem_resp  = '0;
    for (i = 0; i < 16; i++) begin
      mem_array[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);
    end
    forever begin
      tick();
      mem_resp = '0;
      if (!busy && (mem_req.read_q || mem_req.write_q)) begin
        held      = mem_req;
        busy      = 1'b1;
        wait_left = mem_delay;
        if (mem_req.write_q) begin
          mem_array[mem_req.addr[5:2]] = mem_req.data;
        end
      end
      if (busy) begin
        if (wait_left == 0) begin
          busy              = 1'b0;
          mem_resp.read_dn  = held.read_q;
          mem_resp.write_dn = held.write_q;
          mem_resp.addr     = held.addr;
          mem_resp.data     = held.write_q ? held.data : mem_array[held.addr[5:2]];
        end else begin
          wait_left--;
        end
      end
    end
  end

  initial begin
    bit ok;
    int slots;
    rst          = 1'b1;
    cpu_rst_done = 1'b0;
    cpu_req      = '0;
    cpu_msg_in   = cpu_msg_pkg::CPU_R_NONE;
    cpu_ack      = 1'b0;
    repeat (4) begin
      tick();
      check_bit("cpu_rst", cpu_rst, 1'b1);
      check_bit("cpu_sel.q", cpu_sel.q, 1'b0);
      check_quiet();
    end
    rst = 1'b0;
    // cpus still resetting, scheduler must hold off
    repeat (3) begin
      tick();
      check_bit("cpu_rst", cpu_rst, 1'b0);
      check_bit("cpu_sel.q", cpu_sel.q, 1'b0);
      check_quiet();
    end
    cpu_rst_done = 1'b1;
    wait_grant(ok);
    slots = 0;
    while (ok && slots < NUM_SLOTS) begin
      run_slot(ok);
      slots++;
      if (ok && slots < NUM_SLOTS) begin
        wait_grant(ok);
      end
    end
    // last message event lands in the counters one edge later
    tick();
    check_count("num_a", int'(i_dispatcher_top.i_cpu_scheduler.num_a), m_active);
    check_count("num_a + num_na",
                int'(i_dispatcher_top.i_cpu_scheduler.num_a) +
                int'(i_dispatcher_top.i_cpu_scheduler.num_na), 4);
    if (n_start == 0 || n_end == 0) begin
      $display("Start or end message never exercised");
      other_errors++;
    end
    check_bit("cpu_rst", cpu_rst, 1'b0);
    $display("%0d slots, %0d starts, %0d ends, %0d value errors, %0d other errors",
             slots, n_start, n_end, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0 && slots == NUM_SLOTS) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* verilog/cpu_cmd_stage.sv */
`timescale 1ns/10ps

module cpu_cmd_stage (
  input  logic                    clk,
  input  logic                    rst,
  input  cpu_msg_pkg::cpu_sel_t   cpu_sel,
  input  cpu_msg_pkg::cpu_req_t   cpu_req,
  input  cpu_msg_pkg::cpu_msg_e   cpu_msg_in,
  input  logic                    cpu_ack,
  output cpu_msg_pkg::cpu_event_t cpu_event,
  output cpu_msg_pkg::mem_cmd_t   mem_cmd
);

  // set between grant and the first accepted item
  logic armed;

  // what gets taken this cycle, fixed priority
  logic take_rd;
  logic take_wr;
  logic take_ack;

  assign take_rd  = armed && cpu_req.read_q;
  assign take_wr  = armed && !cpu_req.read_q && cpu_req.write_q;
  assign take_ack = armed && !cpu_req.read_q && !cpu_req.write_q && cpu_ack;

  // control and pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      armed         <= 1'b0;
      mem_cmd.read  <= 1'b0;
      mem_cmd.write <= 1'b0;
      cpu_event     <= '0;
    end else begin
      mem_cmd.read  <= take_rd;
      mem_cmd.write <= take_wr;
      cpu_event.ack <= take_ack;
      // message decode, only meaningful with ack
      cpu_event.start <= take_ack && (cpu_msg_in == cpu_msg_pkg::CPU_R_START);
      cpu_event.stop  <= take_ack && (cpu_msg_in == cpu_msg_pkg::CPU_R_END);
      if (cpu_sel.q) begin
        armed <= 1'b1;
      end else if (take_rd || take_wr || take_ack) begin
        // one item per slot
        armed <= 1'b0;
      end
    end
  end

  // access payload, loaded on accept
  always_ff @(posedge clk) begin
    if (take_rd || take_wr) begin
      mem_cmd.addr <= cpu_req.addr;
      // reads carry no data towards memory
      mem_cmd.data <= take_wr ? cpu_req.data : '0;
    end
  end

endmodule

/* verilog/dispatcher_top.sv */
`timescale 1ns/10ps

module dispatcher_top #(
  parameter int CPU_QUANTITY = disp_cfg_pkg::CPU_QUANTITY_DEF
) (
  input  logic                   clk,
  input  logic                   rst,

  // cpu reset handshake
  output logic                   cpu_rst,
  input  logic                   cpu_rst_done,

  // cpu slot bus
  output cpu_msg_pkg::cpu_sel_t  cpu_sel,
  input  cpu_msg_pkg::cpu_req_t  cpu_req,
  input  cpu_msg_pkg::cpu_msg_e  cpu_msg_in,
  input  logic                   cpu_ack,
  output cpu_msg_pkg::cpu_resp_t cpu_resp,

  // external memory port
  output cpu_msg_pkg::mem_req_t  mem_req,
  input  cpu_msg_pkg::mem_resp_t mem_resp,
  output logic                   bus_busy
);

  // stage to stage links
  cpu_msg_pkg::cpu_event_t cpu_event;
  cpu_msg_pkg::mem_cmd_t   mem_cmd;

  // grants slots and counts cpus
  cpu_scheduler #(
    .CPU_QUANTITY(CPU_QUANTITY)
  ) i_cpu_scheduler (
    .clk         (clk),
    .rst         (rst),
    .cpu_rst_done(cpu_rst_done),
    .cpu_rst     (cpu_rst),
    .cpu_event   (cpu_event),
    .cpu_resp    (cpu_resp),
    .cpu_sel     (cpu_sel)
  );

  // picks up what the granted cpu asks for
  cpu_cmd_stage i_cpu_cmd_stage (
    .clk       (clk),
    .rst       (rst),
    .cpu_sel   (cpu_sel),
    .cpu_req   (cpu_req),
    .cpu_msg_in(cpu_msg_in),
    .cpu_ack   (cpu_ack),
    .cpu_event (cpu_event),
    .mem_cmd   (mem_cmd)
  );

  // runs the memory access, result goes back to cpu and scheduler
  mem_access_stage i_mem_access_stage (
    .clk     (clk),
    .rst     (rst),
    .mem_cmd (mem_cmd),
    .mem_req (mem_req),
    .mem_resp(mem_resp),
    .cpu_resp(cpu_resp),
    .bus_busy(bus_busy)
  );

endmodule
